//--- compile.f
obd_pkg.sv
phrase_buffer.sv
pixel_extract.sv
clut_ram.sv
lb_address.sv
ob_sequencer.sv
lb_write_stage.sv
ob_data_path.sv
tb_ob_data_path.sv

//--- tb_ob_data_path.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the object pixel data path
// Table of objects, reference line buffer model and lookup table checks
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tb_ob_data_path;

	// One object of the stimulus table
	typedef struct packed {
		obd_pkg::pix_mode_e mode;
		logic reflected;
		logic transen;
		logic rmw;
		logic [11:0] x0;
		logic [5:0] start_bit;
		logic [6:0] index;
		logic [2:0] phrases;
	} obj_entry_t;

	localparam int N_OBJ = 9;

	logic sys_clk;
	logic resetl;
	logic [obd_pkg::PHRASE_W-1:0] d;
	logic obdlatch;
	logic xld;
	logic obld_1;
	obd_pkg::obj_ctrl_t ctrl_in;
	obd_pkg::cpu_clut_t cpu;
	logic obdready;
	logic obdone;
	obd_pkg::lb_write_t lb;
	logic lben;
	logic rmw1;
	logic offscreen;
	logic [obd_pkg::PIX_W-1:0] dr_out;
	logic dr_oe;

	obj_entry_t obj_table [N_OBJ];
	logic [63:0] phrase_q [8];
	// Lookup table contents as written by the CPU
	logic [15:0] clut_model [256];
	// Expected line buffer words of the current object
	logic [1:0] exp_we [512];
	logic [31:0] exp_wd [512];
	logic seen [512];
	int exp_words;
	// Object left the line by its last step
	logic exp_offscreen;
	int words_seen;
	logic cur_rmw;
	logic [31:0] lcg_state;
	int mismatch_count;
	int fail_count;
	int cycle_count;
	int cycle_limit;

	ob_data_path #(
		.X_W(12),
		.LINE_PIXELS(720)
	) u_ob_data_path (
		.sys_clk(sys_clk),
		.resetl(resetl),
		.d(d),
		.obdlatch(obdlatch),
		.xld(xld),
		.obld_1(obld_1),
		.ctrl_in(ctrl_in),
		.cpu(cpu),
		.obdready(obdready),
		.obdone(obdone),
		.lb(lb),
		.lben(lben),
		.rmw1(rmw1),
		.offscreen(offscreen),
		.dr_out(dr_out),
		.dr_oe(dr_oe)
	);

	initial begin
		sys_clk = 1'b0;
		forever #4 sys_clk = ~sys_clk;
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic int pixel_width(input obd_pkg::pix_mode_e mode);
		case (mode)
			obd_pkg::MODE1: return 1;
			obd_pkg::MODE2: return 2;
			obd_pkg::MODE4: return 4;
			obd_pkg::MODE8: return 8;
			default: return 16;
		endcase
	endfunction

	// Pixel k of a phrase sits at bit k times the width
	function automatic logic [15:0] pixel_at(input logic [63:0] ph, input int k, input int w);
		logic [63:0] mask;
		mask = (64'd1 << w) - 64'd1;
		return 16'((ph >> (k * w)) & mask);
	endfunction

	// Low pixel bits under the object index bits
	function automatic logic [7:0] clut_index(input obj_entry_t obj, input logic [15:0] pix);
		case (obj.mode)
			obd_pkg::MODE1: return {obj.index, pix[0]};
			obd_pkg::MODE2: return {obj.index[6:1], pix[1:0]};
			obd_pkg::MODE4: return {obj.index[6:3], pix[3:0]};
			default: return pix[7:0];
		endcase
	endfunction

	function automatic logic off_line(input obj_entry_t obj, input int x);
		return obj.reflected ? (x < 0) : (x >= 720);
	endfunction

	// Random phrases with some zero pixels forced in
	task automatic gen_phrases(input obj_entry_t obj);
		int p;
		int k;
		int w;
		logic [31:0] r;
		logic [63:0] mask;
		w = pixel_width(obj.mode);
		mask = (64'd1 << w) - 64'd1;
		for (p = 0; p < obj.phrases; p++) begin
			phrase_q[p][63:32] = next_rand();
			phrase_q[p][31:0] = next_rand();
			for (k = 0; k < 64 / w; k++) begin
				r = next_rand();
				if (r[30:29] == 2'b00) begin
					phrase_q[p] = phrase_q[p] & ~(mask << (k * w));
				end
			end
		end
	endtask

	// Walk the pairs as the object would, until it leaves the line
	task automatic build_expected(input obj_entry_t obj);
		int p;
		int ptr;
		int x;
		int w;
		logic stop;
		logic [15:0] pa;
		logic [15:0] pb;
		logic [15:0] da;
		logic [15:0] db;
		logic oa;
		logic ob;
		for (p = 0; p < 512; p++) begin
			exp_we[p] = 2'b00;
			exp_wd[p] = '0;
			seen[p] = 1'b0;
		end
		exp_words = 0;
		x = int'(obj.x0);
		w = pixel_width(obj.mode);
		stop = 1'b0;
		for (p = 0; p < obj.phrases; p++) begin
			ptr = (p == 0) ? int'(obj.start_bit) : 0;
			while (ptr < 64 && !stop) begin
				if (off_line(obj, x)) begin
					stop = 1'b1;
				end else begin
					pa = pixel_at(phrase_q[p], ptr / w, w);
					pb = pixel_at(phrase_q[p], ptr / w + 1, w);
					// Physical mode skips the table
					da = (obj.mode == obd_pkg::MODE16) ? pa : clut_model[clut_index(obj, pa)];
					db = (obj.mode == obd_pkg::MODE16) ? pb : clut_model[clut_index(obj, pb)];
					oa = !(obj.transen && pa == 16'd0);
					ob = !(obj.transen && pb == 16'd0);
					if (oa || ob) begin
						exp_words++;
						if (obj.reflected) begin
							exp_we[x >> 1] = {oa, ob};
							exp_wd[x >> 1] = {da, db};
						end else begin
							exp_we[x >> 1] = {ob, oa};
							exp_wd[x >> 1] = {db, da};
						end
					end
					x = obj.reflected ? x - 2 : x + 2;
					ptr = ptr + 2 * w;
				end
			end
		end
		exp_offscreen = off_line(obj, x);
	endtask

	task automatic load_clut();
		int a;
		logic [31:0] r;
		for (a = 0; a < 256; a++) begin
			r = next_rand();
			clut_model[a] = r[31:16];
			cpu.palen = 1'b1;
			cpu.reads = 1'b0;
			cpu.addr = 8'(a);
			cpu.din = r[31:16];
			@(posedge sys_clk);
			#1;
		end
		cpu = '0;
	endtask

	// Read data shows one cycle after the address
	task automatic check_clut_reads(input int n);
		int i;
		logic [31:0] r;
		for (i = 0; i < n; i++) begin
			r = next_rand();
			cpu.palen = 1'b1;
			cpu.reads = 1'b1;
			cpu.addr = r[23:16];
			@(posedge sys_clk);
			@(negedge sys_clk);
			assert (dr_oe) else begin
				$display("dr_oe stayed low during a CPU read at %0t", $time);
				fail_count++;
			end
			assert (dr_out == clut_model[cpu.addr]) else begin
				$display("mismatch at %0t: dr_out[%0d] got %h expected %h",
					$time, cpu.addr, dr_out, clut_model[cpu.addr]);
				mismatch_count++;
			end
			@(posedge sys_clk);
			#1;
		end
		cpu = '0;
	endtask

	task automatic run_object(input obj_entry_t obj);
		int p;
		gen_phrases(obj);
		build_expected(obj);
		words_seen = 0;
		cur_rmw = obj.rmw;
		ctrl_in.mode = obj.mode;
		ctrl_in.transen = obj.transen;
		ctrl_in.reflected = obj.reflected;
		ctrl_in.rmw = obj.rmw;
		ctrl_in.index = obj.index;
		// Start x and start bit offset share one header cycle
		d = '0;
		d[11:0] = obj.x0;
		d[54:49] = obj.start_bit;
		xld = 1'b1;
		obld_1 = 1'b1;
		@(posedge sys_clk);
		#1;
		xld = 1'b0;
		obld_1 = 1'b0;
		for (p = 0; p < obj.phrases; p++) begin
			while (!obdready) begin
				@(posedge sys_clk);
				#1;
			end
			d = phrase_q[p];
			obdlatch = 1'b1;
			@(posedge sys_clk);
			#1;
			obdlatch = 1'b0;
		end
		d = '0;
		// Sequencer done, then the write pipeline drains
		while (!obdone) begin
			@(posedge sys_clk);
			#1;
		end
		while (lben) begin
			@(posedge sys_clk);
			#1;
		end
		assert (words_seen == exp_words) else begin
			$display("mismatch at %0t: written word count got %0d expected %0d",
				$time, words_seen, exp_words);
			mismatch_count++;
		end
		assert (offscreen == exp_offscreen) else begin
			$display("mismatch at %0t: offscreen got %b expected %b",
				$time, offscreen, exp_offscreen);
			mismatch_count++;
		end
	endtask

	// Each written word against the model by address
	always @(negedge sys_clk) begin
		if (resetl && lb.we != 2'b00) begin
			words_seen = words_seen + 1;
			assert (exp_we[lb.wa] != 2'b00 && !seen[lb.wa]) else begin
				$display("Unexpected or repeated line buffer write to address %0d at %0t",
					lb.wa, $time);
				fail_count++;
			end
			seen[lb.wa] = 1'b1;
			assert (lb.we == exp_we[lb.wa]) else begin
				$display("mismatch at %0t: lb.we[%0d] got %b expected %b",
					$time, lb.wa, lb.we, exp_we[lb.wa]);
				mismatch_count++;
			end
			assert (lb.wd == exp_wd[lb.wa]) else begin
				$display("mismatch at %0t: lb.wd[%0d] got %h expected %h",
					$time, lb.wa, lb.wd, exp_wd[lb.wa]);
				mismatch_count++;
			end
			assert (rmw1 == cur_rmw) else begin
				$display("mismatch at %0t: rmw1 got %b expected %b", $time, rmw1, cur_rmw);
				mismatch_count++;
			end
			// Line buffer stays enabled while words come out
			assert (lben) else begin
				$display("mismatch at %0t: lben got %b expected 1", $time, lben);
				mismatch_count++;
			end
		end
	end

	// Run limit
	always @(posedge sys_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("Timeout, the run did not finish within %0d cycles", cycle_limit);
			$display("Errors: %0d mismatches, %0d other failures",
				mismatch_count, fail_count + 1);
			$display("Test failed");
			$finish;
		end
	end

	initial begin
		int i;
		int total;
		resetl = 1'b0;
		d = '0;
		obdlatch = 1'b0;
		xld = 1'b0;
		obld_1 = 1'b0;
		ctrl_in = '0;
		cpu = '0;
		lcg_state = 32'd17;
		mismatch_count = 0;
		fail_count = 0;
		cycle_count = 0;
		words_seen = 0;
		exp_words = 0;
		exp_offscreen = 1'b0;
		cur_rmw = 1'b0;
		// mode, reflected, transen, rmw, x start, start bit, index, phrases
		obj_table[0] = '{obd_pkg::MODE1, 1'b0, 1'b1, 1'b0, 12'd100, 6'd4, 7'h2a, 3'd2};
		obj_table[1] = '{obd_pkg::MODE2, 1'b0, 1'b1, 1'b0, 12'd200, 6'd8, 7'h35, 3'd2};
		obj_table[2] = '{obd_pkg::MODE4, 1'b0, 1'b0, 1'b0, 12'd10, 6'd16, 7'h4b, 3'd3};
		obj_table[3] = '{obd_pkg::MODE8, 1'b0, 1'b1, 1'b1, 12'd300, 6'd0, 7'h00, 3'd3};
		obj_table[4] = '{obd_pkg::MODE16, 1'b0, 1'b1, 1'b0, 12'd400, 6'd32, 7'h00, 3'd3};
		obj_table[5] = '{obd_pkg::MODE8, 1'b1, 1'b1, 1'b0, 12'd500, 6'd0, 7'h00, 3'd3};
		// Runs past the right edge
		obj_table[6] = '{obd_pkg::MODE4, 1'b0, 1'b1, 1'b0, 12'd700, 6'd0, 7'h11, 3'd2};
		// Reflected through zero
		obj_table[7] = '{obd_pkg::MODE16, 1'b1, 1'b0, 1'b1, 12'd6, 6'd0, 7'h00, 3'd3};
		obj_table[8] = '{obd_pkg::MODE2, 1'b1, 1'b0, 1'b0, 12'd600, 6'd0, 7'h7f, 3'd1};
		total = 0;
		for (i = 0; i < N_OBJ; i++) begin
			total = total + int'(obj_table[i].phrases);
		end
		cycle_limit = total * 70 + 200;

		repeat (8) @(posedge sys_clk);
		#1;
		resetl = 1'b1;
		assert (!lben && lb.we == 2'b00 && !rmw1) else begin
			$display("Line buffer outputs not cleared by reset");
			fail_count++;
		end
		assert (obdone && obdready) else begin
			$display("obdone or obdready low after reset");
			fail_count++;
		end

		load_clut();
		check_clut_reads(8);
		for (i = 0; i < N_OBJ; i++) begin
			run_object(obj_table[i]);
		end
		// Table is the CPU's again once the objects are done
		check_clut_reads(2);

		$display("Errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
		if (mismatch_count == 0 && fail_count == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- ob_data_path.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Object processor pixel data path, top level
// Phrase buffer, pixel extract, lookup table, x counter, FSM, write stage
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module ob_data_path #(
	parameter int X_W = 12,
	parameter int LINE_PIXELS = 720
) (
	input wire logic sys_clk,
	input wire logic resetl,
	input wire logic [obd_pkg::PHRASE_W-1:0] d,
	input wire logic obdlatch,
	input wire logic xld,
	input wire logic obld_1,
	input wire obd_pkg::obj_ctrl_t ctrl_in,
	input wire obd_pkg::cpu_clut_t cpu,
	output logic obdready,
	output logic obdone,
	output obd_pkg::lb_write_t lb,
	output logic lben,
	output logic rmw1,
	output logic offscreen,
	output logic [obd_pkg::PIX_W-1:0] dr_out,
	output logic dr_oe
);

	obd_pkg::obj_ctrl_t ctrl;
	obd_pkg::pix_pair_t pair;
	logic [obd_pkg::PHRASE_W-1:0] cur_phrase;
	logic full;
	logic seq_idle;
	logic next_phrase;
	logic next_pair;
	logic phrase_done;
	logic lb_write;
	logic [8:0] wa;
	logic [obd_pkg::PIX_W-1:0] clut_a;
	logic [obd_pkg::PIX_W-1:0] clut_b;

	// Object attributes come with the phrase
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			ctrl <= '0;
		end else if (obdlatch) begin
			ctrl <= ctrl_in;
		end
	end

	phrase_buffer u_phrase_buffer (
		.sys_clk(sys_clk),
		.resetl(resetl),
		.d(d),
		.obdlatch(obdlatch),
		.next_phrase(next_phrase),
		.offscreen(offscreen),
		.seq_idle(seq_idle),
		.cur_phrase(cur_phrase),
		.full(full),
		.obdready(obdready),
		.obdone(obdone)
	);

	// Start bit offset rides in the phrase header bits
	pixel_extract u_pixel_extract (
		.sys_clk(sys_clk),
		.resetl(resetl),
		.cur_phrase(cur_phrase),
		.ctrl(ctrl),
		.obld_1(obld_1),
		.start_bit(d[54:49]),
		.next_phrase(next_phrase),
		.next_pair(next_pair),
		.pair(pair),
		.phrase_done(phrase_done)
	);

	clut_ram u_clut_ram (
		.sys_clk(sys_clk),
		.cpu(cpu),
		.seq_idle(seq_idle),
		.pair(pair),
		.clut_a(clut_a),
		.clut_b(clut_b),
		.dr_out(dr_out),
		.dr_oe(dr_oe)
	);

	lb_address #(
		.X_W(X_W),
		.LINE_PIXELS(LINE_PIXELS)
	) u_lb_address (
		.sys_clk(sys_clk),
		.resetl(resetl),
		.d_x(d[X_W-1:0]),
		.xld(xld),
		.reflected(ctrl.reflected),
		.next_pair(next_pair),
		.wa(wa),
		.offscreen(offscreen)
	);

	ob_sequencer u_ob_sequencer (
		.sys_clk(sys_clk),
		.resetl(resetl),
		.full(full),
		.rmw(ctrl.rmw),
		.phrase_done(phrase_done),
		.offscreen(offscreen),
		.next_phrase(next_phrase),
		.next_pair(next_pair),
		.lb_write(lb_write),
		.seq_idle(seq_idle),
		.rmw1(rmw1)
	);

	// Word out two cycles after its write decision
	lb_write_stage u_lb_write_stage (
		.sys_clk(sys_clk),
		.resetl(resetl),
		.lb_write(lb_write),
		.pair(pair),
		.clut_a(clut_a),
		.clut_b(clut_b),
		.mode(ctrl.mode),
		.reflected(ctrl.reflected),
		.wa_in(wa),
		.offscreen(offscreen),
		.lb(lb),
		.lben(lben)
	);

endmodule

`default_nettype wire

//--- lb_write_stage.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Line buffer write pipeline: enables, data placement and lben
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module lb_write_stage (
	input wire logic sys_clk,
	input wire logic resetl,
	input wire logic lb_write,
	input wire obd_pkg::pix_pair_t pair,
	input wire logic [obd_pkg::PIX_W-1:0] clut_a,
	input wire logic [obd_pkg::PIX_W-1:0] clut_b,
	input wire obd_pkg::pix_mode_e mode,
	input wire logic reflected,
	input wire logic [8:0] wa_in,
	input wire logic offscreen,
	output obd_pkg::lb_write_t lb,
	output logic lben
);

	// First stage, lined up with the lookup table output
	logic we_a_d;
	logic we_b_d;
	logic [8:0] wa_d;
	logic [2*obd_pkg::PIX_W-1:0] raw_d;
	logic phys_d;
	logic refl_d;
	logic lb_write_d;
	// Pixel data after the physical-mode select
	logic [obd_pkg::PIX_W-1:0] data_a;
	logic [obd_pkg::PIX_W-1:0] data_b;

	// Enables, cleared for see-through or offscreen pixels
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			we_a_d <= 1'b0;
			we_b_d <= 1'b0;
			lb_write_d <= 1'b0;
		end else begin
			we_a_d <= lb_write && pair.opaque_a && !offscreen;
			we_b_d <= lb_write && pair.opaque_b && !offscreen;
			lb_write_d <= lb_write;
		end
	end

	always_ff @(posedge sys_clk) begin
		wa_d <= wa_in;
		raw_d <= pair.raw;
		phys_d <= (mode == obd_pkg::MODE16);
		refl_d <= reflected;
	end

	// 16-bit pixels skip the table
	assign data_a = phys_d ? raw_d[15:0] : clut_a;
	assign data_b = phys_d ? raw_d[31:16] : clut_b;

	// Output register, reflected objects put pixel a in the high half
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			lb.we <= 2'b00;
		end else if (refl_d) begin
			lb.we <= {we_a_d, we_b_d};
		end else begin
			lb.we <= {we_b_d, we_a_d};
		end
	end

	always_ff @(posedge sys_clk) begin
		lb.wa <= wa_d;
		if (refl_d) begin
			lb.wd <= {data_a, data_b};
		end else begin
			lb.wd <= {data_b, data_a};
		end
	end

	// Line buffer held until the last word is out
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			lben <= 1'b0;
		end else begin
			lben <= lb_write || lb_write_d;
		end
	end

endmodule

`default_nettype wire

//--- ob_sequencer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Idle/read/write FSM pacing phrases and pixel pairs
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module ob_sequencer (
	input wire logic sys_clk,
	input wire logic resetl,
	input wire logic full,
	input wire logic rmw,
	input wire logic phrase_done,
	input wire logic offscreen,
	output logic next_phrase,
	output logic next_pair,
	output logic lb_write,
	output logic seq_idle,
	output logic rmw1
);

	obd_pkg::seq_state_e state;
	obd_pkg::seq_state_e state_nxt;
	// Pair cycle starts with a read when read-modify-write
	obd_pkg::seq_state_e pair_start;

	assign pair_start = rmw ? obd_pkg::READ : obd_pkg::WRITE;

	always_comb begin
		state_nxt = state;
		case (state)
			obd_pkg::IDLE: begin
				if (full) begin
					state_nxt = pair_start;
				end
			end
			obd_pkg::READ: begin
				state_nxt = obd_pkg::WRITE;
			end
			default: begin
				// More pairs here, or chain straight into the next phrase
				if (!phrase_done || full) begin
					state_nxt = pair_start;
				end else begin
					state_nxt = obd_pkg::IDLE;
				end
			end
		endcase
		// Running off the line ends the object
		if (offscreen) begin
			state_nxt = obd_pkg::IDLE;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			state <= obd_pkg::IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// Take a phrase when starting up or after the last pair
	assign next_phrase = full && !offscreen
		&& ((state == obd_pkg::IDLE) || ((state == obd_pkg::WRITE) && phrase_done));

	assign next_pair = (state == obd_pkg::WRITE);
	assign lb_write = (state == obd_pkg::WRITE);
	assign seq_idle = (state == obd_pkg::IDLE);

	// Read-modify-write flag follows the phrase being worked on
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			rmw1 <= 1'b0;
		end else if (next_phrase) begin
			rmw1 <= rmw;
		end
	end

endmodule

`default_nettype wire

//--- lb_address.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Line buffer x counter with up/down step and offscreen detection
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module lb_address #(
	parameter int X_W = 12,
	parameter int LINE_PIXELS = 720
) (
	input wire logic sys_clk,
	input wire logic resetl,
	input wire logic [X_W-1:0] d_x,
	input wire logic xld,
	input wire logic reflected,
	input wire logic next_pair,
	output logic [8:0] wa,
	output logic offscreen
);

	// Pixel x of the next pair, always even
	logic [X_W-1:0] x;

	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			x <= '0;
		end else if (xld) begin
			x <= d_x;
		end else if (next_pair) begin
			// Two pixels per word, reflected objects walk left
			if (reflected) begin
				x <= x - X_W'(2);
			end else begin
				x <= x + X_W'(2);
			end
		end
	end

	// Word address drops the pixel-in-word bit
	assign wa = x[9:1];

	// Left edge is the sign going negative, right edge is the line width
	assign offscreen = reflected ? x[X_W-1] : (x >= X_W'(LINE_PIXELS));

endmodule

`default_nettype wire

//--- clut_ram.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-bank colour lookup table, pixel pair lookup and CPU access
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module clut_ram (
	input wire logic sys_clk,
	input wire obd_pkg::cpu_clut_t cpu,
	input wire logic seq_idle,
	input wire obd_pkg::pix_pair_t pair,
	output logic [obd_pkg::PIX_W-1:0] clut_a,
	output logic [obd_pkg::PIX_W-1:0] clut_b,
	output logic [obd_pkg::PIX_W-1:0] dr_out,
	output logic dr_oe
);

	// Same contents in both banks so a pair looks up in one cycle
	logic [obd_pkg::PIX_W-1:0] bank_a [256];
	logic [obd_pkg::PIX_W-1:0] bank_b [256];
	logic [7:0] addr_a;
	logic [7:0] addr_b;
	logic cpu_wr;

	// CPU owns the table while the sequencer is idle
	assign addr_a = seq_idle ? cpu.addr : pair.idx_a;
	assign addr_b = seq_idle ? cpu.addr : pair.idx_b;

	assign cpu_wr = seq_idle && cpu.palen && !cpu.reads;

	// CPU write lands in both banks
	always_ff @(posedge sys_clk) begin
		if (cpu_wr) begin
			bank_a[addr_a] <= cpu.din;
			bank_b[addr_b] <= cpu.din;
		end
	end

	// Registered reads
	always_ff @(posedge sys_clk) begin
		clut_a <= bank_a[addr_a];
		clut_b <= bank_b[addr_b];
	end

	// CPU reads always come back from bank a
	assign dr_out = clut_a;
	assign dr_oe = cpu.palen && cpu.reads;

endmodule

`default_nettype wire

//--- pixel_extract.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pixel pair extraction, lookup index forming and transparency test
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module pixel_extract (
	input wire logic sys_clk,
	input wire logic resetl,
	input wire logic [obd_pkg::PHRASE_W-1:0] cur_phrase,
	input wire obd_pkg::obj_ctrl_t ctrl,
	input wire logic obld_1,
	input wire logic [5:0] start_bit,
	input wire logic next_phrase,
	input wire logic next_pair,
	output obd_pkg::pix_pair_t pair,
	output logic phrase_done
);

	// Bit pointer to pixel a, and the start offset for the next phrase
	logic [5:0] ptr;
	logic [5:0] ptr_start;
	logic [5:0] step;
	logic [6:0] ptr_sum;
	logic [obd_pkg::PHRASE_W-1:0] sel;
	logic [obd_pkg::PIX_W-1:0] pix_a;
	logic [obd_pkg::PIX_W-1:0] pix_b;

	// First phrase of an object may start mid phrase, later ones at bit 0
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			ptr_start <= '0;
		end else if (obld_1) begin
			ptr_start <= start_bit;
		end else if (next_phrase) begin
			ptr_start <= '0;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			ptr <= '0;
		end else if (next_phrase) begin
			ptr <= ptr_start;
		end else if (next_pair) begin
			ptr <= ptr_sum[5:0];
		end
	end

	// Carry out of the phrase marks the last pair
	assign ptr_sum = {1'b0, ptr} + {1'b0, step};
	assign phrase_done = ptr_sum[6];

	// Pixel a at the pointer, pixel b right above it
	always_comb begin
		sel = cur_phrase >> ptr;
		pix_a = sel[15:0];
		pix_b = sel[31:16];
		step = 6'd32;
		pair.idx_a = sel[7:0];
		pair.idx_b = sel[23:16];
		case (ctrl.mode)
			obd_pkg::MODE1: begin
				pix_a = {15'b0, sel[0]};
				pix_b = {15'b0, sel[1]};
				step = 6'd2;
				pair.idx_a = {ctrl.index, sel[0]};
				pair.idx_b = {ctrl.index, sel[1]};
			end
			obd_pkg::MODE2: begin
				pix_a = {14'b0, sel[1:0]};
				pix_b = {14'b0, sel[3:2]};
				step = 6'd4;
				pair.idx_a = {ctrl.index[6:1], sel[1:0]};
				pair.idx_b = {ctrl.index[6:1], sel[3:2]};
			end
			obd_pkg::MODE4: begin
				pix_a = {12'b0, sel[3:0]};
				pix_b = {12'b0, sel[7:4]};
				step = 6'd8;
				pair.idx_a = {ctrl.index[6:3], sel[3:0]};
				pair.idx_b = {ctrl.index[6:3], sel[7:4]};
			end
			obd_pkg::MODE8: begin
				// Full index from the pixel
				pix_a = {8'b0, sel[7:0]};
				pix_b = {8'b0, sel[15:8]};
				step = 6'd16;
				pair.idx_a = sel[7:0];
				pair.idx_b = sel[15:8];
			end
			default: begin
				// Physical mode keeps the defaults above
			end
		endcase
		pair.raw = sel[31:0];
		// Zero is see-through only with transen
		pair.opaque_a = !(ctrl.transen && (pix_a == '0));
		pair.opaque_b = !(ctrl.transen && (pix_b == '0));
	end

endmodule

`default_nettype wire

//--- phrase_buffer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Phrase double buffer with full flag, ready and done status
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module phrase_buffer (
	input wire logic sys_clk,
	input wire logic resetl,
	input wire logic [obd_pkg::PHRASE_W-1:0] d,
	input wire logic obdlatch,
	input wire logic next_phrase,
	input wire logic offscreen,
	input wire logic seq_idle,
	output logic [obd_pkg::PHRASE_W-1:0] cur_phrase,
	output logic full,
	output logic obdready,
	output logic obdone
);

	// Incoming phrase, waiting for the sequencer
	logic [obd_pkg::PHRASE_W-1:0] pend_phrase;

	// Data latches
	always_ff @(posedge sys_clk) begin
		if (obdlatch) begin
			pend_phrase <= d;
		end
		// Working phrase taken from the latch
		if (next_phrase) begin
			cur_phrase <= pend_phrase;
		end
	end

	// A latch together with a move leaves the new phrase pending
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			full <= 1'b0;
		end else if (obdlatch) begin
			full <= 1'b1;
		end else if (next_phrase || offscreen) begin
			// Offscreen drops whatever is still pending
			full <= 1'b0;
		end
	end

	// Room for another phrase once the pending one moves
	assign obdready = !full || next_phrase;

	// Nothing pending and the sequencer has stopped
	assign obdone = seq_idle && !full;

endmodule

`default_nettype wire

//--- obd_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Object data path shared definitions
// Pixel modes, sequencer states, widths and the bundles between blocks
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package obd_pkg;

	// One phrase of packed object data
	localparam int PHRASE_W = 64;

	// One pixel, also one lookup table entry
	localparam int PIX_W = 16;

	// Pixel depth of the current object
	typedef enum logic [2:0] {
		MODE1,
		MODE2,
		MODE4,
		MODE8,
		MODE16
	} pix_mode_e;

	// Line buffer cycle sequencer
	typedef enum logic [1:0] {
		IDLE,
		READ,
		WRITE
	} seq_state_e;

	// Object attributes, held for the whole object
	typedef struct packed {
		pix_mode_e mode;
		logic transen;
		logic reflected;
		logic rmw;
		// Lookup index bits 7..1
		logic [6:0] index;
	} obj_ctrl_t;

	// CPU port onto the lookup table
	typedef struct packed {
		logic palen;
		logic reads;
		logic [7:0] addr;
		logic [PIX_W-1:0] din;
	} cpu_clut_t;

	// Pixel pair taken from the working phrase
	typedef struct packed {
		logic [7:0] idx_a;
		logic [7:0] idx_b;
		// Both pixels as they sit in the phrase, for physical mode
		logic [2*PIX_W-1:0] raw;
		logic opaque_a;
		logic opaque_b;
	} pix_pair_t;

	// Line buffer write port, one word holds two pixels
	typedef struct packed {
		logic [8:0] wa;
		logic [1:0] we;
		logic [2*PIX_W-1:0] wd;
	} lb_write_t;

endpackage

`default_nettype wire
